// ==== verilog.f ====
+incdir+rtl
rtl/nocArbPkg.sv
rtl/arbCfgIf.sv
rtl/holdTimer.sv
rtl/portArbiter.sv
rtl/arbCfgRegs.sv
rtl/nocArbTop.sv
sim/tb_nocArb.sv

// ==== Makefile ====
TOP = tb_nocArb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f verilog.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_nocArb.sv ====
`include "nocArb_cfg.svh"

module tb_nocArb;
  timeunit 1ns;
  timeprecision 100ps;
  import nocArbPkg::*;

  localparam logic [`APB_AW-1:0] regCtrl    = 'h0;
  localparam logic [`APB_AW-1:0] regHoldCap = 'h4;
  localparam logic [`APB_AW-1:0] regGrants  = 'h8;

  logic                              clk;
  logic                              rst;
  logic                              PSEL;
  logic                              PENABLE;
  logic                              PWRITE;
  logic [`APB_AW-1:0]                PADDR;
  logic [`APB_DW-1:0]                PWDATA;
  logic [`APB_DW-1:0]                PRDATA;
  logic                              PREADY;
  logic                              PSLVERR;
  logic [`NUM_PORTS-1:0]             req;
  flitKind_e [`NUM_PORTS-1:0]        flitKind;
  logic [`NUM_PORTS-1:0][`LEN_W-1:0] length;
  grantState_e                       grant;

  integer seed;
  int     errors;
  int     checks;
  int     testsRun;
  int     testsFailed;
  int     errAtStart;
  string  curTest;

  // Reference model
  int                    mGrant;  // 0 is Idle and 1 to 5 are Local to South
  logic                  mNewGrant;
  logic [`NUM_PORTS-1:0] mMask;
  logic [`LEN_W-1:0]     mCap;
  logic [15:0]           mCount;
  int                    mLimit [`NUM_PORTS];
  int                    mCnt [`NUM_PORTS];

  nocArbTop dut0 (
    .clk(clk), .rst(rst), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
    .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
    .req(req), .flitKind(flitKind), .length(length), .grant(grant)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    #100000;
    $display("Watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic startTest(input string name);
    curTest    = name;
    errAtStart = errors;
    testsRun++;
  endtask

  task automatic finishTest();
    if (errors == errAtStart)
      $display("%s ... ok", curTest);
    else
    begin
      testsFailed++;
      $display("%s ... failed with %0d errors", curTest, errors - errAtStart);
    end
  endtask

  // Search the rotation after cur, or all ports from Local when Idle
  function automatic int rotatePick(input int cur, input logic [`NUM_PORTS-1:0] counting);
    int pick;
    int idx;
    int span;
    pick = 0;
    span = (cur == 0) ? `NUM_PORTS : `NUM_PORTS - 1;
    for (int off = span; off >= 1; off--)
    begin
      idx = (cur == 0) ? off - 1 : (cur - 1 + off) % `NUM_PORTS;
      if (counting[idx])
        pick = idx + 1;  // Nearest one is written last
    end
    return pick;
  endfunction

  task automatic modelEdge();
    logic [`NUM_PORTS-1:0] counting;
    logic                  keep;
    int                    next;
    counting = req & mMask;
    keep     = 1'b0;
    if (mGrant != 0)
      keep = counting[mGrant-1] && (mCnt[mGrant-1] != mLimit[mGrant-1]);
    next = keep ? mGrant : rotatePick(mGrant, counting);
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (flitKind[i] == Header)
        mLimit[i] = (length[i] < mCap) ? int'(length[i]) : int'(mCap);
      mCnt[i] = (keep && i == mGrant - 1) ? mCnt[i] + 1 : 0;
    end
    if (mNewGrant)
      mCount = mCount + 16'd1;
    mNewGrant = (next != 0) && (next != mGrant);
    if (PSEL && PENABLE && PWRITE && PADDR == regCtrl)
      mMask = PWDATA[`NUM_PORTS-1:0];
    if (PSEL && PENABLE && PWRITE && PADDR == regHoldCap)
      mCap = PWDATA[`LEN_W-1:0];
    mGrant = next;
  endtask

  // Model and DUT share the edge and grant is compared once it settles
  task automatic step();
    @(posedge clk);
    modelEdge();
    #1;
    check({curTest, " grant"}, mGrant, grant);
  endtask

  task automatic idleInputs();
    req    = '0;
    length = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
      flitKind[i] = None;
  endtask

  task automatic quiesce();
    idleInputs();
    step();
    step();
  endtask

  task automatic randomInputs();
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      req[i]      = (($random(seed) & 3) != 0);
      flitKind[i] = flitKind_e'(3'($random(seed) & 3));
      length[i]   = `LEN_W'($random(seed) & 15);
    end
  endtask

  task automatic apbAccess(input logic write, input logic [`APB_AW-1:0] addr,
                           input logic [`APB_DW-1:0] wdata,
                           output logic [`APB_DW-1:0] rdata, output logic err);
    int waits;
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = write;
    PADDR   = addr;
    PWDATA  = wdata;
    step();
    PENABLE = 1'b1;
    #1;
    waits = 0;
    while (!PREADY && waits < 16)
    begin
      step();
      #1;
      waits++;
    end
    if (!PREADY)
    begin
      errors++;
      $display("%s: APB access to %0h never saw PREADY", curTest, addr);
    end
    rdata = PRDATA;
    err   = PSLVERR;
    step();  // Write lands on this edge
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
  endtask

  task automatic apbWrite(input logic [`APB_AW-1:0] addr, input logic [`APB_DW-1:0] data,
                          output logic err);
    logic [`APB_DW-1:0] ignored;
    apbAccess(1'b1, addr, data, ignored, err);
  endtask

  task automatic apbRead(input logic [`APB_AW-1:0] addr, output logic [`APB_DW-1:0] data,
                         output logic err);
    apbAccess(1'b0, addr, '0, data, err);
  endtask

  task automatic readExpect(input string name, input logic [`APB_AW-1:0] addr,
                            input logic [31:0] expected);
    logic [31:0] data;
    logic        err;
    apbRead(addr, data, err);
    check({curTest, " ", name}, expected, data);
    check({curTest, " ", name, " PSLVERR"}, 0, err);
  endtask

  function automatic logic [31:0] ctrlValue();
    logic [31:0] v;
    v                  = '0;
    v[`NUM_PORTS-1:0]  = mMask;
    v[10:8]            = mGrant[2:0];
    return v;
  endfunction

  // One port alone is held holdLen cycles, sees one Idle cycle and is granted again
  task automatic holdRun(input int port, input logic [`LEN_W-1:0] len, input int holdLen);
    grantState_e target;
    int          tries;
    int          held;
    target = grantState_e'(port + 1);
    quiesce();
    req[port]      = 1'b1;
    flitKind[port] = Header;
    length[port]   = len;
    step();
    flitKind[port] = Body;
    tries = 0;
    while (grant != target && tries < 20)
    begin
      step();
      tries++;
    end
    if (grant != target)
    begin
      errors++;
      $display("%s: port %0d was never granted", curTest, port);
    end
    held = 0;
    while (grant == target && held < 64)
    begin
      held++;
      step();
    end
    check({curTest, " hold length"}, holdLen, held);
    check({curTest, " idle gap"}, Idle, grant);
    step();
    check({curTest, " regrant"}, target, grant);
    quiesce();
  endtask

  initial
  begin
    logic [31:0] data;
    logic        err;
    seed        = 32'h73f1_fbd5;
    errors      = 0;
    checks      = 0;
    testsRun    = 0;
    testsFailed = 0;
    curTest     = "reset";
    rst         = 1'b1;
    PSEL        = 1'b0;
    PENABLE     = 1'b0;
    PWRITE      = 1'b0;
    PADDR       = '0;
    PWDATA      = '0;
    idleInputs();
    mGrant    = 0;
    mNewGrant = 1'b0;
    mMask     = '1;
    mCap      = '1;
    mCount    = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      mLimit[i] = 0;
      mCnt[i]   = 0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    startTest("reset values");
    step();
    readExpect("CTRL", regCtrl, 32'h1F);
    readExpect("HOLDCAP", regHoldCap, 32'hFFF);
    readExpect("GRANTS", regGrants, 32'h0);
    finishTest();

    startTest("random traffic");
    for (int c = 0; c < 2000; c++)
    begin
      randomInputs();
      step();
    end
    finishTest();

    startTest("single port hold");
    holdRun(2, 5, 6);
    holdRun(4, 0, 1);  // Zero length still gets one cycle
    finishTest();

    startTest("hold cap and mask");
    quiesce();
    apbWrite(regHoldCap, 32'd2, err);
    check({curTest, " HOLDCAP write PSLVERR"}, 0, err);
    holdRun(1, 10, 3);
    apbWrite(regCtrl, 32'h16, err);  // Local and West masked off
    check({curTest, " CTRL write PSLVERR"}, 0, err);
    for (int c = 0; c < 300; c++)
    begin
      randomInputs();
      step();
      check({curTest, " masked port granted"}, 0, grant == Local || grant == West);
    end
    quiesce();
    apbWrite(regCtrl, 32'h1F, err);
    apbWrite(regHoldCap, 32'hFFF, err);
    finishTest();

    startTest("grant counter");
    quiesce();
    check({curTest, " grants seen"}, 1, mCount != 0);
    readExpect("GRANTS", regGrants, {16'h0, mCount});
    req[2]      = 1'b1;  // East held so CTRL shows a live grant
    flitKind[2] = Header;
    length[2]   = 15;
    step();
    flitKind[2] = Body;
    check({curTest, " East granted"}, East, grant);
    readExpect("CTRL", regCtrl, ctrlValue());
    quiesce();
    finishTest();

    startTest("APB errors");
    quiesce();
    apbRead(4'hC, data, err);
    check({curTest, " unmapped read PSLVERR"}, 1, err);
    check({curTest, " unmapped read data"}, 0, data);
    apbWrite(4'h2, 32'h3, err);
    check({curTest, " unmapped write PSLVERR"}, 1, err);
    apbWrite(regGrants, 32'h1234, err);
    check({curTest, " GRANTS write PSLVERR"}, 1, err);
    readExpect("CTRL", regCtrl, ctrlValue());
    readExpect("HOLDCAP", regHoldCap, {20'h0, mCap});
    readExpect("GRANTS", regGrants, {16'h0, mCount});
    finishTest();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== rtl/nocArbTop.sv ====
`include "nocArb_cfg.svh"

module nocArbTop (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  PSEL,
  input  logic                                  PENABLE,
  input  logic                                  PWRITE,
  input  logic [`APB_AW-1:0]                    PADDR,
  input  logic [`APB_DW-1:0]                    PWDATA,
  output logic [`APB_DW-1:0]                    PRDATA,
  output logic                                  PREADY,
  output logic                                  PSLVERR,
  input  logic [`NUM_PORTS-1:0]                 req,
  input  nocArbPkg::flitKind_e [`NUM_PORTS-1:0] flitKind,
  input  logic [`NUM_PORTS-1:0][`LEN_W-1:0]     length,
  output nocArbPkg::grantState_e                grant
);

  arbCfgIf cfgBus ();

  arbCfgRegs regs0 (
    .clk     (clk),
    .rst     (rst),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR),
    .cfg     (cfgBus.regs)
  );

  portArbiter arb0 (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .flitKind (flitKind),
    .length   (length),
    .cfg      (cfgBus.arb)
  );

  // Registered inside the arbiter
  assign grant = cfgBus.grant;

endmodule

// ==== rtl/arbCfgRegs.sv ====
`include "nocArb_cfg.svh"

module arbCfgRegs (
  input  logic               clk,
  input  logic               rst,
  input  logic               PSEL,
  input  logic               PENABLE,
  input  logic               PWRITE,
  input  logic [`APB_AW-1:0] PADDR,
  input  logic [`APB_DW-1:0] PWDATA,
  output logic [`APB_DW-1:0] PRDATA,
  output logic               PREADY,
  output logic               PSLVERR,
  arbCfgIf.regs              cfg
);
  localparam logic [`APB_AW-1:0] addrCtrl    = 'h0;
  localparam logic [`APB_AW-1:0] addrHoldCap = 'h4;
  localparam logic [`APB_AW-1:0] addrGrants  = 'h8;

  logic                  access;
  logic                  addrHit;
  logic                  wrEn;
  logic [`NUM_PORTS-1:0] enableMask;
  logic [`LEN_W-1:0]     holdCap;
  logic [15:0]           grantCount;

  assign access  = PSEL && PENABLE;
  assign addrHit = (PADDR == addrCtrl) || (PADDR == addrHoldCap) || (PADDR == addrGrants);
  assign PREADY  = 1'b1;  // No wait states
  assign PSLVERR = access && (!addrHit || (PWRITE && PADDR == addrGrants));
  assign wrEn    = access && PWRITE && !PSLVERR;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      enableMask <= '1;
      holdCap    <= '1;
      grantCount <= '0;
    end
    else
    begin
      if (wrEn && PADDR == addrCtrl)
        enableMask <= PWDATA[`NUM_PORTS-1:0];
      if (wrEn && PADDR == addrHoldCap)
        holdCap <= PWDATA[`LEN_W-1:0];
      if (cfg.newGrant)
        grantCount <= grantCount + 16'd1;  // Wraps at 16 bits
    end
  end

  always_comb
  begin
    PRDATA = '0;
    if (access && !PWRITE)
    begin
      case (PADDR)
        addrCtrl:
        begin
          PRDATA[`NUM_PORTS-1:0] = enableMask;
          PRDATA[10:8]           = cfg.grant;  // Live grant state
        end
        addrHoldCap: PRDATA[`LEN_W-1:0] = holdCap;
        addrGrants:  PRDATA[15:0]       = grantCount;
        default:     PRDATA             = '0;
      endcase
    end
  end

  assign cfg.enableMask = enableMask;
  assign cfg.holdCap    = holdCap;

  // Errors only in an access phase that followed its setup phase
  apbErrInAccess: assert property (@(posedge clk) disable iff (rst)
    PSLVERR |-> PENABLE && $past(PSEL && !PENABLE));

endmodule

// ==== rtl/portArbiter.sv ====
`include "nocArb_cfg.svh"

module portArbiter (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [`NUM_PORTS-1:0]                 req,
  input  nocArbPkg::flitKind_e [`NUM_PORTS-1:0] flitKind,
  input  logic [`NUM_PORTS-1:0][`LEN_W-1:0]     length,
  arbCfgIf.arb                                  cfg
);
  import nocArbPkg::*;

  grantState_e           grant;
  grantState_e           nextGrant;
  logic                  newGrant;
  logic                  keep;
  logic [`NUM_PORTS-1:0] countVec;
  logic [`NUM_PORTS-1:0] grantOh;
  logic [`NUM_PORTS-1:0] expiredVec;
  logic [`NUM_PORTS-1:0] runVec;

  // First counting port after cur, wrapping around and skipping cur.
  // From Idle the search covers all ports starting at Local.
  function automatic grantState_e pickNext(grantState_e cur, logic [`NUM_PORTS-1:0] cnt);
    int          first;
    int          tries;
    int          idx;
    grantState_e pick;
    pick  = Idle;
    first = (cur == Idle) ? 0 : int'(cur);
    tries = (cur == Idle) ? `NUM_PORTS : `NUM_PORTS - 1;
    for (int k = 0; k < `NUM_PORTS; k++)
    begin
      idx = (first + k) % `NUM_PORTS;
      if (k < tries && pick == Idle && cnt[idx])
        pick = grantState_e'(idx + 1);
    end
    return pick;
  endfunction

  assign countVec = req & cfg.enableMask;

  always_comb
  begin
    for (int i = 0; i < `NUM_PORTS; i++)
      grantOh[i] = (grant == grantState_e'(i + 1));
  end

  // Current port stays while it still requests and has time left
  assign keep      = |(grantOh & countVec & ~expiredVec);
  assign runVec    = keep ? grantOh : '0;
  assign nextGrant = keep ? grant : pickNext(grant, countVec);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant    <= Idle;
      newGrant <= 1'b0;
    end
    else
    begin
      grant    <= nextGrant;
      newGrant <= (nextGrant != Idle) && (nextGrant != grant);
    end
  end

  assign cfg.grant    = grant;
  assign cfg.newGrant = newGrant;

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : gTimer
    holdTimer timer (
      .clk      (clk),
      .rst      (rst),
      .flitKind (flitKind[i]),
      .length   (length[i]),
      .holdCap  (cfg.holdCap),
      .run      (runVec[i]),
      .expired  (expiredVec[i])
    );
  end

  grantLegal: assert property (@(posedge clk) disable iff (rst)
    grant inside {Idle, Local, North, East, West, South});

  // A new grant must go to a port that was asking and enabled
  newGrantReq: assert property (@(posedge clk) disable iff (rst)
    newGrant |-> |(grantOh & $past(countVec)));

endmodule

// ==== rtl/holdTimer.sv ====
`include "nocArb_cfg.svh"

module holdTimer (
  input  logic                 clk,
  input  logic                 rst,
  input  nocArbPkg::flitKind_e flitKind,
  input  logic [`LEN_W-1:0]    length,
  input  logic [`LEN_W-1:0]    holdCap,
  input  logic                 run,
  output logic                 expired
);
  import nocArbPkg::*;

  logic [`LEN_W-1:0] capped;
  logic [`LEN_W-1:0] limit;
  logic [`LEN_W-1:0] count;

  assign capped = (length < holdCap) ? length : holdCap;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitKind == Header)
        limit <= capped;
      // Count only while the port is held and kept
      count <= run ? count + 1'b1 : '0;
    end
  end

  assign expired = (count == limit);

endmodule

// ==== rtl/arbCfgIf.sv ====
`include "nocArb_cfg.svh"

interface arbCfgIf;
  import nocArbPkg::*;

  logic [`NUM_PORTS-1:0] enableMask;
  logic [`LEN_W-1:0]     holdCap;
  grantState_e           grant;
  logic                  newGrant;  // One cycle per grant change to a port

  modport regs (
    output enableMask,
    output holdCap,
    input  grant,
    input  newGrant
  );

  modport arb (
    input  enableMask,
    input  holdCap,
    output grant,
    output newGrant
  );

endinterface

// ==== rtl/nocArbPkg.sv ====
package nocArbPkg;

  // Arbiter state that also names the granted port
  // Port index is the value minus one
  typedef enum logic [2:0] {
    Idle  = 3'd0,
    Local = 3'd1,
    North = 3'd2,
    East  = 3'd3,
    West  = 3'd4,
    South = 3'd5
  } grantState_e;

  typedef enum logic [2:0] {
    None   = 3'd0,
    Header = 3'd1,  // Carries the packet length
    Body   = 3'd2,
    Tail   = 3'd3
  } flitKind_e;

endpackage

// ==== rtl/nocArb_cfg.svh ====
`ifndef NOCARB_CFG_SVH
`define NOCARB_CFG_SVH

// Router input ports Local, North, East, West, South
`define NUM_PORTS 5

// Packet length and hold counter width
`define LEN_W 12

`define APB_AW 4
`define APB_DW 32

`endif
